/* verification/mem_test_input.txt */
# pair port op addr wdata strb expected, all hex; pair 1 starts this line with the next one
# port 0 is load/store, 1 is fetch; op 1 is a store (nonzero strb), op 0 a read
0 0 1 00000040 1122334455667788 ff 0000000000000000
0 0 0 00000040 0000000000000000 00 1122334455667788
0 0 1 00000080 0123456789abcdef ff 0000000000000000
0 0 1 00000080 aaaaaaaaaaaaaaaa 0f 0000000000000000
0 0 0 00000080 0000000000000000 00 01234567aaaaaaaa
0 0 1 00000080 5555555555555555 c0 0000000000000000
0 0 1 00000080 ffeeddccbbaa9988 81 0000000000000000
0 0 0 00000080 0000000000000000 00 ff554567aaaaaa88
0 1 0 00000040 0000000000000000 00 1122334455667788
0 0 1 000007f8 cafef00d12345678 ff 0000000000000000
0 1 0 000007f8 0000000000000000 00 cafef00d12345678
0 0 1 00000100 0f0e0d0c0b0a0908 ff 0000000000000000
1 0 0 00000100 0000000000000000 00 0f0e0d0c0b0a0908
0 1 0 00000080 0000000000000000 00 ff554567aaaaaa88
1 0 1 00000200 89abcdef01234567 ff 0000000000000000
0 1 0 000007f8 0000000000000000 00 cafef00d12345678
0 0 0 00000200 0000000000000000 00 89abcdef01234567
0 0 0 000007f8 0000000000000000 00 cafef00d12345678
1 1 0 00000100 0000000000000000 00 0f0e0d0c0b0a0908
0 0 0 00000040 0000000000000000 00 1122334455667788
0 0 1 00000040 ffffffffffffffff 3c 0000000000000000
0 1 0 00000040 0000000000000000 00 1122ffffffff7788
0 0 1 00000300 0000000000000001 ff 0000000000000000
0 1 0 00000200 0000000000000000 00 89abcdef01234567

/* verilog.f */
design/cpu_mem_pkg.sv
design/axi_pkg.sv
design/axi_arbiter.sv
design/axi_sram.sv
design/mem_subsystem.sv
verification/tb_mem_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_subsystem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_mem_subsystem.sv */
// Run from the project root for the vector file path; at most 64 vectors, addresses below 0x800
`default_nettype none

module tb_mem_subsystem;
    import cpu_mem_pkg::*;

    localparam int MAX_VECTORS     = 64;
    localparam int CYCLE           = 100;
    localparam int RESPONSE_CYCLES = 30;
    localparam int WATCHDOG_CYCLES = 40;

    typedef struct packed {
        logic  pair;
        logic  fetch;
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
        word_t exp_data;
    } vector_t;

    logic    clk;
    logic    reset;
    logic    inst_en;
    addr_t   inst_addr;
    logic    inst_ready;
    word_t   inst_rdata;
    logic    inst_valid;
    logic    data_en;
    strb_t   data_wen;
    addr_t   data_addr;
    word_t   data_wdata;
    logic    data_ready;
    word_t   data_rdata;
    logic    data_valid;

    vector_t vectors [MAX_VECTORS];
    int      num_vectors;
    int      value_errors;
    int      other_errors;
    int      seed;

    mem_subsystem DUT (
        .clk        (clk),
        .reset      (reset),
        .inst_en    (inst_en),
        .inst_addr  (inst_addr),
        .inst_ready (inst_ready),
        .inst_rdata (inst_rdata),
        .inst_valid (inst_valid),
        .data_en    (data_en),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ready (data_ready),
        .data_rdata (data_rdata),
        .data_valid (data_valid)
    );

    always #(CYCLE / 2) clk = ~clk;

    // --------------------
    // Vector file
    // --------------------
    task automatic load_vectors();
        int    fd;
        int    n;
        int    c;
        logic  pair;
        logic  port;
        logic  op;
        addr_t addr;
        word_t wdata;
        strb_t strb;
        word_t exp_data;
        fd = $fopen("verification/mem_test_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/mem_test_input.txt for reading");
            other_errors++;
            return;
        end
        while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h", pair, port, op, addr, wdata, strb, exp_data);
            if (n == 7 && op == (strb != '0) && !(port && op)) begin
                vectors[num_vectors] = '{pair: pair, fetch: port, write: op, addr: addr,
                                         wdata: wdata, strb: strb, exp_data: exp_data};
                num_vectors++;
            end else begin
                if (n > 0) begin
                    $display("Malformed line in the vector file after vector %0d", num_vectors);
                    other_errors++;
                end
                // Skip a comment or bad line up to its newline
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!inst_ready && !inst_valid && !data_ready && !data_valid) else begin
                $display("CHECK FAILED at %0t: ready or valid pulse with no request pending",
                         $time);
                value_errors++;
            end
        end
    endtask

    // --------------------
    // One vector, or a pair started on the same edge
    // --------------------
    task automatic run_group(input int first, input int count);
        int    slot [2];
        logic  wait_ready [2];
        logic  wait_valid [2];
        int    ready_at [2];
        word_t rdata [2];
        logic  [1:0] rdy;
        logic  [1:0] vld;
        int    port;
        int    cycles;
        string pname;
        for (int p = 0; p < 2; p++) begin
            slot[p]       = -1;
            wait_ready[p] = 1'b0;
            wait_valid[p] = 1'b0;
            ready_at[p]   = -1;
        end
        for (int k = first; k < first + count; k++) begin
            port = vectors[k].fetch;
            if (slot[port] >= 0) begin
                $display("Vectors %0d and %0d are paired on the same port", slot[port], k);
                other_errors++;
                return;
            end
            slot[port] = k;
        end
        if (slot[0] >= 0) begin
            data_en       = 1'b1;
            data_wen      = vectors[slot[0]].strb;
            data_addr     = vectors[slot[0]].addr;
            data_wdata    = vectors[slot[0]].wdata;
            wait_ready[0] = 1'b1;
        end
        if (slot[1] >= 0) begin
            inst_en       = 1'b1;
            inst_addr     = vectors[slot[1]].addr;
            wait_ready[1] = 1'b1;
        end
        cycles = 0;
        while ((wait_ready[0] || wait_valid[0] || wait_ready[1] || wait_valid[1]) &&
               cycles < RESPONSE_CYCLES * count) begin
            @(negedge clk);
            cycles++;
            rdy      = {inst_ready, data_ready};
            vld      = {inst_valid, data_valid};
            rdata[0] = data_rdata;
            rdata[1] = inst_rdata;
            for (int p = 0; p < 2; p++) begin
                pname = (p == 0) ? "load/store" : "fetch";
                if (rdy[p]) begin
                    assert (wait_ready[p]) else begin
                        $display("CHECK FAILED at %0t: unexpected ready on the %s port",
                                 $time, pname);
                        value_errors++;
                    end
                    if (wait_ready[p]) begin
                        wait_ready[p] = 1'b0;
                        wait_valid[p] = !vectors[slot[p]].write;
                        ready_at[p]   = cycles;
                        if (p == 0) begin
                            data_en = 1'b0;
                        end else begin
                            inst_en = 1'b0;
                        end
                    end
                end
                if (vld[p]) begin
                    assert (wait_valid[p]) else begin
                        $display("CHECK FAILED at %0t: unexpected valid on the %s port",
                                 $time, pname);
                        value_errors++;
                    end
                    if (wait_valid[p]) begin
                        wait_valid[p] = 1'b0;
                        assert (rdata[p] == vectors[slot[p]].exp_data) else begin
                            $display("CHECK FAILED at %0t: %s read of %h gave %h, expected %h",
                                     $time, pname, vectors[slot[p]].addr, rdata[p],
                                     vectors[slot[p]].exp_data);
                            value_errors++;
                        end
                    end
                end
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (wait_ready[p] || wait_valid[p]) begin
                $display("Timeout on the %s port: no %s within %0d cycles",
                         (p == 0) ? "load/store" : "fetch", wait_ready[p] ? "ready" : "valid",
                         cycles);
                other_errors++;
            end
        end
        data_en = 1'b0;
        inst_en = 1'b0;
        // Load beats a fetch raised on the same edge
        if (slot[0] >= 0 && slot[1] >= 0 && !vectors[slot[0]].write && ready_at[1] >= 0) begin
            assert (ready_at[0] >= 0 && ready_at[0] < ready_at[1]) else begin
                $display("CHECK FAILED at %0t: fetch accepted before the concurrent load", $time);
                value_errors++;
            end
        end
    endtask

    initial begin
        int i;
        int count;
        int gap;
        seed         = 99;
        clk          = 1'b0;
        reset        = 1'b1;
        inst_en      = 1'b0;
        inst_addr    = '0;
        data_en      = 1'b0;
        data_wen     = '0;
        data_addr    = '0;
        data_wdata   = '0;
        num_vectors  = 0;
        value_errors = 0;
        other_errors = 0;
        load_vectors();
        if (num_vectors == 0) begin
            $display("No vectors were read, nothing was tested");
            other_errors++;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        idle_cycles(4);
        i = 0;
        while (i < num_vectors) begin
            count = (vectors[i].pair && i + 1 < num_vectors) ? 2 : 1;
            run_group(i, count);
            i += count;
            gap = $unsigned($random(seed)) % 4;
            idle_cycles(gap);
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (num_vectors > 0);
        #(num_vectors * WATCHDOG_CYCLES * CYCLE);
        $display("Watchdog expired, the run did not finish in time");
        other_errors++;
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* design/mem_subsystem.sv */
// Memory subsystem top; requesters hold their inputs until ready and wait for valid before reissuing
`default_nettype none

module mem_subsystem (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      inst_en,
    input  wire cpu_mem_pkg::addr_t  inst_addr,
    output logic                     inst_ready,
    output cpu_mem_pkg::word_t       inst_rdata,
    output logic                     inst_valid,
    input  wire                      data_en,
    input  wire cpu_mem_pkg::strb_t  data_wen,
    input  wire cpu_mem_pkg::addr_t  data_addr,
    input  wire cpu_mem_pkg::word_t  data_wdata,
    output logic                     data_ready,
    output cpu_mem_pkg::word_t       data_rdata,
    output logic                     data_valid
);
    import axi_pkg::*;

    // --------------------
    // AXI channels
    // --------------------
    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    logic    arvalid, arready;
    logic    rvalid, rready;
    logic    awvalid, awready;
    logic    wvalid, wready;
    logic    bvalid, bready;

    axi_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .inst_en    (inst_en),
        .inst_addr  (inst_addr),
        .inst_ready (inst_ready),
        .inst_rdata (inst_rdata),
        .inst_valid (inst_valid),
        .data_en    (data_en),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ready (data_ready),
        .data_rdata (data_rdata),
        .data_valid (data_valid),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    axi_sram u_sram (
        .clk     (clk),
        .reset   (reset),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

`default_nettype wire

/* design/axi_sram.sv */
// Single-beat AXI slave, 256 x 64-bit words at address bits 10:3; contents undefined after reset
`default_nettype none

module axi_sram (
    input  wire                   clk,
    input  wire                   reset,
    input  wire axi_pkg::axi_ar_t ar,
    input  wire                   arvalid,
    output logic                  arready,
    output axi_pkg::axi_r_t       r,
    output logic                  rvalid,
    input  wire                   rready,
    input  wire axi_pkg::axi_aw_t aw,
    input  wire                   awvalid,
    output logic                  awready,
    input  wire axi_pkg::axi_w_t  w,
    input  wire                   wvalid,
    output logic                  wready,
    output axi_pkg::axi_b_t       b,
    output logic                  bvalid,
    input  wire                   bready
);
    import cpu_mem_pkg::*;
    import axi_pkg::*;

    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

    typedef enum logic [2:0] {
        WR_IDLE, WR_NEED_W, WR_NEED_AW, WR_APPLY, WR_RESP
    } wr_state_t;

    word_t     mem [SRAM_DEPTH];
    rd_state_t rd_state, rd_next;
    wr_state_t wr_state, wr_next;
    axi_aw_t   aw_q;
    axi_w_t    w_q;
    sram_idx_t rd_idx;
    sram_idx_t wr_idx;
    logic      ar_hs;
    logic      aw_hs;
    logic      w_hs;

    assign ar_hs  = arvalid && arready;
    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign rd_idx = ar.addr[SRAM_IDX_LSB +: SRAM_IDX_W];
    assign wr_idx = aw_q.addr[SRAM_IDX_LSB +: SRAM_IDX_W];
    assign b      = '{id: aw_q.id, resp: AXI_RESP_OKAY};

    // --------------------
    // Next-state logic
    // --------------------
    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: rd_next = ar_hs ? RD_RESP : RD_IDLE;
            default: rd_next = (rvalid && rready) ? RD_IDLE : RD_RESP;
        endcase
    end

    // aw and w may arrive in either order
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: begin
                if (aw_hs && w_hs) begin
                    wr_next = WR_APPLY;
                end else if (aw_hs) begin
                    wr_next = WR_NEED_W;
                end else if (w_hs) begin
                    wr_next = WR_NEED_AW;
                end
            end
            WR_NEED_W:  wr_next = w_hs ? WR_APPLY : WR_NEED_W;
            WR_NEED_AW: wr_next = aw_hs ? WR_APPLY : WR_NEED_AW;
            WR_APPLY:   wr_next = WR_RESP;
            default:    wr_next = (bvalid && bready) ? WR_IDLE : WR_RESP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            rd_state <= rd_next;
            wr_state <= wr_next;
            arready  <= (rd_next == RD_IDLE);
            rvalid   <= (rd_next == RD_RESP);
            awready  <= (wr_next == WR_IDLE) || (wr_next == WR_NEED_AW);
            wready   <= (wr_next == WR_IDLE) || (wr_next == WR_NEED_W);
            bvalid   <= (wr_next == WR_RESP);
        end
    end

    // --------------------
    // Storage and payloads
    // --------------------
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            r <= '{id: ar.id, data: mem[rd_idx], resp: AXI_RESP_OKAY, last: 1'b1};
        end
        if (aw_hs) begin
            aw_q <= aw;
        end
        if (w_hs) begin
            w_q <= w;
        end
    end

    // Untouched lanes keep their old value
    always_ff @(posedge clk) begin
        if (wr_state == WR_APPLY) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (w_q.strb[i]) begin
                    mem[wr_idx][i*8 +: 8] <= w_q.data[i*8 +: 8];
                end
            end
        end
    end

    a_ar_single_beat: assert property (@(posedge clk) disable iff (reset)
        arvalid |-> ar.len == '0 && ar.size == AXI_SIZE_8B);

    a_aw_single_beat: assert property (@(posedge clk) disable iff (reset)
        awvalid |-> aw.len == '0 && aw.size == AXI_SIZE_8B);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(r));

endmodule

`default_nettype wire

/* design/axi_arbiter.sv */
// Strobe-to-AXI bridge; one read and one write in flight, loads beat fetches, responses ignored
`default_nettype none

module axi_arbiter (
    input  wire                      clk,
    input  wire                      reset,
    // Fetch port
    input  wire                      inst_en,
    input  wire cpu_mem_pkg::addr_t  inst_addr,
    output logic                     inst_ready,
    output cpu_mem_pkg::word_t       inst_rdata,
    output logic                     inst_valid,
    // Load/store port
    input  wire                      data_en,
    input  wire cpu_mem_pkg::strb_t  data_wen,
    input  wire cpu_mem_pkg::addr_t  data_addr,
    input  wire cpu_mem_pkg::word_t  data_wdata,
    output logic                     data_ready,
    output cpu_mem_pkg::word_t       data_rdata,
    output logic                     data_valid,
    // AXI master
    output axi_pkg::axi_ar_t         ar,
    output logic                     arvalid,
    input  wire                      arready,
    input  wire axi_pkg::axi_r_t     r,
    input  wire                      rvalid,
    output logic                     rready,
    output axi_pkg::axi_aw_t         aw,
    output logic                     awvalid,
    input  wire                      awready,
    output axi_pkg::axi_w_t          w,
    output logic                     wvalid,
    input  wire                      wready,
    input  wire axi_pkg::axi_b_t     b,
    input  wire                      bvalid,
    output logic                     bready
);
    import axi_pkg::*;

    typedef enum logic [2:0] {
        AR_IDLE, AR_FETCH, AR_LOAD, AR_FETCH_OK, AR_LOAD_OK
    } ar_state_t;

    typedef enum logic [2:0] {
        R_IDLE, R_WAIT_FETCH, R_WAIT_LOAD, R_GOT_INST, R_GOT_DATA
    } r_state_t;

    typedef enum logic [2:0] {
        AW_IDLE, AW_WAIT_BOTH, AW_WAIT_W, AW_WAIT_AW, AW_OK
    } aw_state_t;

    typedef enum logic [1:0] {
        B_IDLE, B_WAIT, B_GOT
    } b_state_t;

    ar_state_t ar_state, ar_next;
    r_state_t  r_state, r_next;
    aw_state_t aw_state, aw_next;
    b_state_t  b_state, b_next;

    logic load_req;
    logic store_req;
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;

    assign load_req  = data_en && (data_wen == '0);
    assign store_req = data_en && (data_wen != '0);
    assign ar_hs     = arvalid && arready;
    assign r_hs      = rvalid && rready;
    assign aw_hs     = awvalid && awready;
    assign w_hs      = wvalid && wready;

    // Store payload comes straight from the held request
    assign aw = '{id: ID_DATA, addr: data_addr, len: '0, size: AXI_SIZE_8B,
                  burst: AXI_BURST_INCR};
    assign w  = '{data: data_wdata, strb: data_wen, last: 1'b1};

    // --------------------
    // Next-state logic
    // --------------------
    always_comb begin
        ar_next = ar_state;
        case (ar_state)
            // New read only once the previous beat is back
            AR_IDLE: begin
                if (r_state == R_IDLE && load_req) begin
                    ar_next = AR_LOAD;
                end else if (r_state == R_IDLE && inst_en) begin
                    ar_next = AR_FETCH;
                end
            end
            AR_FETCH: ar_next = ar_hs ? AR_FETCH_OK : AR_FETCH;
            AR_LOAD:  ar_next = ar_hs ? AR_LOAD_OK : AR_LOAD;
            default:  ar_next = AR_IDLE;
        endcase
    end

    always_comb begin
        r_next = r_state;
        case (r_state)
            R_IDLE: begin
                if (ar_state == AR_FETCH_OK) begin
                    r_next = R_WAIT_FETCH;
                end else if (ar_state == AR_LOAD_OK) begin
                    r_next = R_WAIT_LOAD;
                end
            end
            R_WAIT_FETCH: r_next = (r_hs && r.id == ID_FETCH) ? R_GOT_INST : R_WAIT_FETCH;
            R_WAIT_LOAD:  r_next = (r_hs && r.id == ID_DATA) ? R_GOT_DATA : R_WAIT_LOAD;
            default:      r_next = R_IDLE;
        endcase
    end

    always_comb begin
        aw_next = aw_state;
        case (aw_state)
            AW_IDLE: begin
                if (store_req && b_state == B_IDLE) begin
                    aw_next = AW_WAIT_BOTH;
                end
            end
            AW_WAIT_BOTH: begin
                if (aw_hs && w_hs) begin
                    aw_next = AW_OK;
                end else if (aw_hs) begin
                    aw_next = AW_WAIT_W;
                end else if (w_hs) begin
                    aw_next = AW_WAIT_AW;
                end
            end
            AW_WAIT_W:  aw_next = w_hs ? AW_OK : AW_WAIT_W;
            AW_WAIT_AW: aw_next = aw_hs ? AW_OK : AW_WAIT_AW;
            default:    aw_next = AW_IDLE;
        endcase
    end

    always_comb begin
        b_next = b_state;
        case (b_state)
            B_IDLE:  b_next = (aw_state == AW_OK) ? B_WAIT : B_IDLE;
            B_WAIT:  b_next = (bvalid && bready) ? B_GOT : B_WAIT;
            default: b_next = B_IDLE;
        endcase
    end

    // --------------------
    // State and handshakes
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ar_state   <= AR_IDLE;
            r_state    <= R_IDLE;
            aw_state   <= AW_IDLE;
            b_state    <= B_IDLE;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            bready     <= 1'b0;
            inst_ready <= 1'b0;
            inst_valid <= 1'b0;
            data_ready <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            ar_state   <= ar_next;
            r_state    <= r_next;
            aw_state   <= aw_next;
            b_state    <= b_next;
            arvalid    <= (ar_next == AR_FETCH) || (ar_next == AR_LOAD);
            rready     <= (r_next == R_WAIT_FETCH) || (r_next == R_WAIT_LOAD);
            awvalid    <= (aw_next == AW_WAIT_BOTH) || (aw_next == AW_WAIT_AW);
            wvalid     <= (aw_next == AW_WAIT_BOTH) || (aw_next == AW_WAIT_W);
            bready     <= (b_next == B_WAIT);
            inst_ready <= (ar_next == AR_FETCH_OK);
            inst_valid <= (r_next == R_GOT_INST);
            // Address accepted for a load, or store response back
            data_ready <= (ar_next == AR_LOAD_OK) || (b_next == B_GOT);
            data_valid <= (r_next == R_GOT_DATA);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_state == AR_IDLE && ar_next != AR_IDLE) begin
            ar.id    <= (ar_next == AR_LOAD) ? ID_DATA : ID_FETCH;
            ar.addr  <= (ar_next == AR_LOAD) ? data_addr : inst_addr;
            ar.len   <= '0;
            ar.size  <= AXI_SIZE_8B;
            ar.burst <= AXI_BURST_INCR;
        end
        if (r_next == R_GOT_INST) begin
            inst_rdata <= r.data;
        end
        if (r_next == R_GOT_DATA) begin
            data_rdata <= r.data;
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_arvalid_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid);

    a_awvalid_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid);

    a_rready_idle: assert property (@(posedge clk) disable iff (reset)
        rready |-> r_state != R_IDLE);

    // Beat must answer the read still outstanding on ar
    a_r_id_match: assert property (@(posedge clk) disable iff (reset)
        r_hs |-> r.id == ar.id);

endmodule

`default_nettype wire

/* design/axi_pkg.sv */
// AXI4 payloads for single-beat 64-bit transfers only; no bursts, responses always OKAY
`default_nettype none

package axi_pkg;

    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

    // --------------------
    // Encodings
    // --------------------
    localparam axi_id_t    ID_FETCH       = 4'd0;
    localparam axi_id_t    ID_DATA        = 4'd1;
    localparam axi_size_t  AXI_SIZE_8B    = 3'd3;
    localparam axi_burst_t AXI_BURST_INCR = 2'd1;
    localparam axi_resp_t  AXI_RESP_OKAY  = 2'd0;

    // SRAM word index taken from address bits 10:3
    localparam int SRAM_DEPTH   = 256;
    localparam int SRAM_IDX_W   = $clog2(SRAM_DEPTH);
    localparam int SRAM_IDX_LSB = 3;

    typedef logic [SRAM_IDX_W-1:0] sram_idx_t;

    // --------------------
    // Channel payloads
    // --------------------
    typedef struct packed {
        axi_id_t             id;
        cpu_mem_pkg::addr_t  addr;
        axi_len_t            len;
        axi_size_t           size;
        axi_burst_t          burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        axi_id_t             id;
        cpu_mem_pkg::word_t  data;
        axi_resp_t           resp;
        logic                last;
    } axi_r_t;

    typedef struct packed {
        cpu_mem_pkg::word_t  data;
        cpu_mem_pkg::strb_t  strb;
        logic                last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t             id;
        axi_resp_t           resp;
    } axi_b_t;

endpackage

`default_nettype wire

/* design/cpu_mem_pkg.sv */
// CPU-side types for 64-bit words on 32-bit byte addresses; a zero strobe means a read
`default_nettype none

package cpu_mem_pkg;

    // --------------------
    // Word geometry
    // --------------------
    localparam int WORD_BYTES = 8;

    // Byte address, word aligned by the requester
    typedef logic [31:0] addr_t;

    typedef logic [WORD_BYTES*8-1:0] word_t;

    // One enable per byte lane
    typedef logic [WORD_BYTES-1:0] strb_t;

endpackage

`default_nettype wire
